/* common/ex_alu_pkg.sv */
// Execute stage ALU package with datapath widths and the ALU opcode set
package ex_alu_pkg;

  // Operand and result width
  localparam int unsigned DATA_W     = 32;
  // Register file index width
  localparam int unsigned REG_ADDR_W = 5;

  // ALU opcodes
  // Compare group EQ..GEU drives the branch decision only
  typedef enum logic [3:0] {
    ADD  = 4'h0,
    SUB  = 4'h1,
    AND  = 4'h2,
    OR   = 4'h3,
    XOR  = 4'h4,
    SLL  = 4'h5,
    SRL  = 4'h6,
    SRA  = 4'h7,
    SLT  = 4'h8,
    SLTU = 4'h9,
    EQ   = 4'ha,
    NE   = 4'hb,
    LT   = 4'hc,
    GE   = 4'hd,
    LTU  = 4'he,
    GEU  = 4'hf
  } alu_op_e;

endpackage

/* common/ex_mult_pkg.sv */
// Multiplier package with the multiply opcodes and the sequencing states
package ex_mult_pkg;

  // Multiply opcodes
  // MUL, MAC give the low word, MULH, MULHU the high word
  typedef enum logic [1:0] {
    MUL   = 2'd0,
    MAC   = 2'd1,
    MULH  = 2'd2,
    MULHU = 2'd3
  } mult_op_e;

  // High products spend one extra cycle in STEP
  typedef enum logic {
    IDLE = 1'b0,
    STEP = 1'b1
  } mult_state_e;

endpackage

/* common/mult_if.sv */
// Multiply request and response bus between the execute stage and the multiplier
`timescale 1ns/1ps

interface mult_if;

  import ex_alu_pkg::*;
  import ex_mult_pkg::*;

  // Request side, level held by decode while EX stalls
  logic              en;
  mult_op_e          op;
  logic [DATA_W-1:0] op_a;
  logic [DATA_W-1:0] op_b;
  // Accumulate addend for MAC
  logic [DATA_W-1:0] op_c;

  // Response side
  logic [DATA_W-1:0] result;
  // Low while the unit needs another cycle
  logic              ready;
  // High in the second cycle of a high product
  logic              multicycle;

  // Execute stage view
  modport stage (output en, op, op_a, op_b, op_c,
                 input  result, ready, multicycle);

  // Multiplier view
  modport unit  (input  en, op, op_a, op_b, op_c,
                 output result, ready, multicycle);

endinterface

/* ex_stage/ex_alu.sv */
// Single-cycle integer ALU with arithmetic, logic, shifts and branch compares
`timescale 1ns/1ps

module ex_alu
(
  input  ex_alu_pkg::alu_op_e             operator_i,
  input  logic [ex_alu_pkg::DATA_W-1:0]   operand_a_i,
  input  logic [ex_alu_pkg::DATA_W-1:0]   operand_b_i,
  output logic [ex_alu_pkg::DATA_W-1:0]   result_o,
  output logic                            comparison_result_o
);

  import ex_alu_pkg::*;

  // Shared adder, one guard bit on top for the compare sign
  logic              adder_sub;
  logic              cmp_signed;
  logic [DATA_W:0]   adder_a;
  logic [DATA_W:0]   adder_b;
  logic [DATA_W:0]   adder_res;

  // Compare flags
  logic              is_lt;
  logic              is_eq;

  // Shift amount, low five bits of b
  logic [4:0]        shamt;

  //////////////////////////////////////////////////////////////////////
  // Adder and compare
  //////////////////////////////////////////////////////////////////////

  // Everything except ADD runs the adder as a - b
  assign adder_sub  = (operator_i != ADD);
  // Signed compares extend with the sign bit, the rest with zero
  assign cmp_signed = (operator_i == SLT) || (operator_i == LT) || (operator_i == GE);

  assign adder_a = {cmp_signed & operand_a_i[DATA_W-1], operand_a_i};
  assign adder_b = {cmp_signed & operand_b_i[DATA_W-1], operand_b_i};

  // Two's complement subtract via inverted b and carry in
  assign adder_res = adder_a + (adder_b ^ {(DATA_W+1){adder_sub}})
                     + {{DATA_W{1'b0}}, adder_sub};

  // Guard bit is the sign of the exact difference
  assign is_lt = adder_res[DATA_W];
  // Zero low word after subtract means equal operands
  assign is_eq = (adder_res[DATA_W-1:0] == '0);

  assign shamt = operand_b_i[4:0];

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    result_o            = '0;
    comparison_result_o = 1'b0;
    case (operator_i)
      ADD, SUB: result_o = adder_res[DATA_W-1:0];
      AND:      result_o = operand_a_i & operand_b_i;
      OR:       result_o = operand_a_i | operand_b_i;
      XOR:      result_o = operand_a_i ^ operand_b_i;
      SLL:      result_o = operand_a_i << shamt;
      SRL:      result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign
      SRA:      result_o = $signed(operand_a_i) >>> shamt;
      // Set-less-than yields 0 or 1
      SLT, SLTU: result_o = {{(DATA_W-1){1'b0}}, is_lt};
      // Branch compares, result stays zero
      EQ:       comparison_result_o = is_eq;
      NE:       comparison_result_o = ~is_eq;
      LT, LTU:  comparison_result_o = is_lt;
      GE, GEU:  comparison_result_o = ~is_lt;
      default:
      begin
        result_o            = '0;
        comparison_result_o = 1'b0;
      end
    endcase
  end

endmodule

/* ex_stage/ex_mult.sv */
// Multiply/accumulate unit with one-cycle low products and two-cycle high products
`timescale 1ns/1ps

module ex_mult
(
  input  logic   clk,
  input  logic   rst_n,
  mult_if.unit   mif,
  // Instruction leaves EX on this cycle
  input  logic   ex_ready_i
);

  import ex_alu_pkg::*;
  import ex_mult_pkg::*;

  mult_state_e         state_q;
  mult_state_e         state_d;

  // Low word path
  logic [DATA_W-1:0]   prod_lo;
  logic [DATA_W-1:0]   low_result;

  // High word path, 64-bit operands after extension
  logic                hi_op;
  logic                hi_signed;
  logic [2*DATA_W-1:0] hi_a;
  logic [2*DATA_W-1:0] hi_b;
  logic [2*DATA_W-1:0] prod_full;
  logic [DATA_W-1:0]   high_q;

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  // Low 32 bits are sign agnostic
  assign prod_lo    = mif.op_a * mif.op_b;
  assign low_result = (mif.op == MAC) ? prod_lo + mif.op_c : prod_lo;

  assign hi_op     = (mif.op == MULH) || (mif.op == MULHU);
  assign hi_signed = (mif.op == MULH);

  // Sign or zero extend to 64 bits, low 64 of the product are exact
  assign hi_a = {{DATA_W{hi_signed & mif.op_a[DATA_W-1]}}, mif.op_a};
  assign hi_b = {{DATA_W{hi_signed & mif.op_b[DATA_W-1]}}, mif.op_b};

  assign prod_full = hi_a * hi_b;

  // High word captured in IDLE, presented from STEP
  // Stays put while EX is stalled in STEP
  always_ff @(posedge clk)
  begin
    if (state_q == IDLE && mif.en)
    begin
      high_q <= prod_full[2*DATA_W-1:DATA_W];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencing FSM
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
      begin
        // High op takes a second cycle
        if (mif.en && hi_op)
        begin
          state_d = STEP;
        end
      end
      STEP:
      begin
        // Leave once the instruction moves on
        if (ex_ready_i)
        begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Response
  assign mif.ready      = (state_q == STEP) || !(mif.en && hi_op);
  assign mif.multicycle = (state_q == STEP);
  assign mif.result     = (state_q == STEP) ? high_q : low_result;

endmodule

/* ex_stage/ex_stage.sv */
// Execute stage with ALU, multiplier, result select, EX/WB register and stall logic
`timescale 1ns/1ps

module ex_stage
(
  input  logic                                clk,
  input  logic                                rst_n,

  // ALU request from decode
  input  ex_alu_pkg::alu_op_e                 alu_operator_i,
  input  logic [ex_alu_pkg::DATA_W-1:0]       alu_operand_a_i,
  input  logic [ex_alu_pkg::DATA_W-1:0]       alu_operand_b_i,
  input  logic [ex_alu_pkg::DATA_W-1:0]       alu_operand_c_i,

  // Multiplier request from decode
  input  logic                                mult_en_i,
  input  ex_mult_pkg::mult_op_e               mult_operator_i,
  input  logic [ex_alu_pkg::DATA_W-1:0]       mult_operand_a_i,
  input  logic [ex_alu_pkg::DATA_W-1:0]       mult_operand_b_i,
  input  logic [ex_alu_pkg::DATA_W-1:0]       mult_operand_c_i,

  input  logic                                branch_in_ex_i,
  input  logic [ex_alu_pkg::REG_ADDR_W-1:0]   regfile_alu_waddr_i,
  input  logic                                regfile_alu_we_i,
  // Passed on to WB
  input  logic                                regfile_we_i,
  input  logic [ex_alu_pkg::REG_ADDR_W-1:0]   regfile_waddr_i,

  input  logic                                csr_access_i,
  input  logic [ex_alu_pkg::DATA_W-1:0]       csr_rdata_i,

  input  logic                                lsu_ready_ex_i,
  input  logic                                wb_ready_i,

  // EX/WB register
  output logic [ex_alu_pkg::REG_ADDR_W-1:0]   regfile_waddr_wb_o,
  output logic                                regfile_we_wb_o,

  // Forwarding to decode
  output logic [ex_alu_pkg::REG_ADDR_W-1:0]   regfile_alu_waddr_fw_o,
  output logic                                regfile_alu_we_fw_o,
  output logic [ex_alu_pkg::DATA_W-1:0]       regfile_alu_wdata_fw_o,

  // Branch outcome to fetch
  output logic [ex_alu_pkg::DATA_W-1:0]       jump_target_o,
  output logic                                branch_decision_o,

  output logic                                mult_multicycle_o,
  output logic                                ex_ready_o,
  output logic                                ex_valid_o
);

  import ex_alu_pkg::*;

  logic [DATA_W-1:0] alu_result;
  logic              alu_cmp_result;

  mult_if mult_bus ();

  //////////////////////////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////////////////////////

  ex_alu alu_i
  (
    .operator_i          ( alu_operator_i  ),
    .operand_a_i         ( alu_operand_a_i ),
    .operand_b_i         ( alu_operand_b_i ),
    .result_o            ( alu_result      ),
    .comparison_result_o ( alu_cmp_result  )
  );

  // Multiply request straight from decode
  assign mult_bus.en   = mult_en_i;
  assign mult_bus.op   = mult_operator_i;
  assign mult_bus.op_a = mult_operand_a_i;
  assign mult_bus.op_b = mult_operand_b_i;
  assign mult_bus.op_c = mult_operand_c_i;

  ex_mult mult_i
  (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .mif        ( mult_bus   ),
    .ex_ready_i ( ex_ready_o )
  );

  assign mult_multicycle_o = mult_bus.multicycle;

  // Result select, multiplier over CSR over ALU
  assign regfile_alu_wdata_fw_o = mult_en_i    ? mult_bus.result :
                                  csr_access_i ? csr_rdata_i     : alu_result;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;

  // Branch target precomputed by decode in operand c
  assign jump_target_o     = alu_operand_c_i;
  assign branch_decision_o = alu_cmp_result;

  //////////////////////////////////////////////////////////////////////
  // Stall control and EX/WB register
  //////////////////////////////////////////////////////////////////////

  // ALU never stalls, so only the multiplier and the neighbours count
  assign ex_valid_o = mult_bus.ready & lsu_ready_ex_i & wb_ready_i;
  // A branch resolves here and never needs WB
  assign ex_ready_o = ex_valid_o | branch_in_ex_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      regfile_we_wb_o    <= 1'b0;
      regfile_waddr_wb_o <= '0;
    end
    else if (ex_valid_o)
    begin
      regfile_we_wb_o <= regfile_we_i;
      // Address only moves with a real write
      if (regfile_we_i)
      begin
        regfile_waddr_wb_o <= regfile_waddr_i;
      end
    end
    else if (wb_ready_i)
    begin
      // Bubble into WB
      regfile_we_wb_o <= 1'b0;
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_ex_top -f src.f -o sim_ex_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_ex_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTBENCH PASSED" sim.log; then
  echo "Result: pass"
  exit 0
fi

echo "Result: fail"
exit 1

/* src.f */
common/ex_alu_pkg.sv
common/ex_mult_pkg.sv
common/mult_if.sv
ex_stage/ex_alu.sv
ex_stage/ex_mult.sv
ex_stage/ex_stage.sv
src/ex_top.sv
tb/ex_top_sva.sv
tb/tb_ex_top.sv

/* src/ex_top.sv */
// Execute subsystem top level exposing plain pipeline ports around the execute stage
`timescale 1ns/1ps

module ex_top
(
  input  logic                                clk,
  input  logic                                rst_n,

  input  ex_alu_pkg::alu_op_e                 alu_operator_i,
  input  logic [ex_alu_pkg::DATA_W-1:0]       alu_operand_a_i,
  input  logic [ex_alu_pkg::DATA_W-1:0]       alu_operand_b_i,
  input  logic [ex_alu_pkg::DATA_W-1:0]       alu_operand_c_i,

  input  logic                                mult_en_i,
  input  ex_mult_pkg::mult_op_e               mult_operator_i,
  input  logic [ex_alu_pkg::DATA_W-1:0]       mult_operand_a_i,
  input  logic [ex_alu_pkg::DATA_W-1:0]       mult_operand_b_i,
  input  logic [ex_alu_pkg::DATA_W-1:0]       mult_operand_c_i,

  input  logic                                branch_in_ex_i,
  input  logic [ex_alu_pkg::REG_ADDR_W-1:0]   regfile_alu_waddr_i,
  input  logic                                regfile_alu_we_i,
  input  logic                                regfile_we_i,
  input  logic [ex_alu_pkg::REG_ADDR_W-1:0]   regfile_waddr_i,

  input  logic                                csr_access_i,
  input  logic [ex_alu_pkg::DATA_W-1:0]       csr_rdata_i,

  input  logic                                lsu_ready_ex_i,
  input  logic                                wb_ready_i,

  output logic [ex_alu_pkg::REG_ADDR_W-1:0]   regfile_waddr_wb_o,
  output logic                                regfile_we_wb_o,
  output logic [ex_alu_pkg::REG_ADDR_W-1:0]   regfile_alu_waddr_fw_o,
  output logic                                regfile_alu_we_fw_o,
  output logic [ex_alu_pkg::DATA_W-1:0]       regfile_alu_wdata_fw_o,
  output logic [ex_alu_pkg::DATA_W-1:0]       jump_target_o,
  output logic                                branch_decision_o,
  output logic                                mult_multicycle_o,
  output logic                                ex_ready_o,
  output logic                                ex_valid_o
);

  // Decode, LSU, CSR file and WB attach here
  ex_stage ex_stage_i
  (
    .clk                    ( clk                    ),
    .rst_n                  ( rst_n                  ),
    .alu_operator_i         ( alu_operator_i         ),
    .alu_operand_a_i        ( alu_operand_a_i        ),
    .alu_operand_b_i        ( alu_operand_b_i        ),
    .alu_operand_c_i        ( alu_operand_c_i        ),
    .mult_en_i              ( mult_en_i              ),
    .mult_operator_i        ( mult_operator_i        ),
    .mult_operand_a_i       ( mult_operand_a_i       ),
    .mult_operand_b_i       ( mult_operand_b_i       ),
    .mult_operand_c_i       ( mult_operand_c_i       ),
    .branch_in_ex_i         ( branch_in_ex_i         ),
    .regfile_alu_waddr_i    ( regfile_alu_waddr_i    ),
    .regfile_alu_we_i       ( regfile_alu_we_i       ),
    .regfile_we_i           ( regfile_we_i           ),
    .regfile_waddr_i        ( regfile_waddr_i        ),
    .csr_access_i           ( csr_access_i           ),
    .csr_rdata_i            ( csr_rdata_i            ),
    .lsu_ready_ex_i         ( lsu_ready_ex_i         ),
    .wb_ready_i             ( wb_ready_i             ),
    .regfile_waddr_wb_o     ( regfile_waddr_wb_o     ),
    .regfile_we_wb_o        ( regfile_we_wb_o        ),
    .regfile_alu_waddr_fw_o ( regfile_alu_waddr_fw_o ),
    .regfile_alu_we_fw_o    ( regfile_alu_we_fw_o    ),
    .regfile_alu_wdata_fw_o ( regfile_alu_wdata_fw_o ),
    .jump_target_o          ( jump_target_o          ),
    .branch_decision_o      ( branch_decision_o      ),
    .mult_multicycle_o      ( mult_multicycle_o      ),
    .ex_ready_o             ( ex_ready_o             ),
    .ex_valid_o             ( ex_valid_o             )
  );

endmodule

/* tb/ex_top_sva.sv */
// Concurrent checks on execute stage stall rules and EX/WB reset state
`timescale 1ns/1ps

module ex_top_sva
(
  input logic clk,
  input logic rst_n,
  input logic ex_valid_i,
  input logic ex_ready_i,
  input logic wb_ready_i,
  input logic branch_in_ex_i,
  input logic regfile_we_wb_i,
  input logic mult_multicycle_i
);

  import ex_mult_pkg::*;

  mult_state_e mult_state;

  // Multicycle flag is high exactly in STEP
  assign mult_state = mult_multicycle_i ? STEP : IDLE;

  valid_implies_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> ex_ready_i)
    else $error("ex_valid_o high while ex_ready_o low");

  wb_stall_blocks_valid: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |-> !ex_valid_i)
    else $error("ex_valid_o high while wb_ready_i low");

  branch_forces_ready: assert property (@(posedge clk) disable iff (!rst_n)
    branch_in_ex_i |-> ex_ready_i)
    else $error("ex_ready_o low with a branch in EX");

  // Stalled high product stays in STEP
  step_held_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (mult_state == STEP && !ex_ready_i) |=> mult_state == STEP)
    else $error("multiplier left STEP while EX was stalled");

  // First edge after reset release
  we_clear_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !regfile_we_wb_i)
    else $error("regfile_we_wb_o set right after reset");

endmodule

bind ex_top ex_top_sva sva_i
(
  .clk               ( clk               ),
  .rst_n             ( rst_n             ),
  .ex_valid_i        ( ex_valid_o        ),
  .ex_ready_i        ( ex_ready_o        ),
  .wb_ready_i        ( wb_ready_i        ),
  .branch_in_ex_i    ( branch_in_ex_i    ),
  .regfile_we_wb_i   ( regfile_we_wb_o   ),
  .mult_multicycle_i ( mult_multicycle_o )
);

/* tb/tb_ex_top.sv */
// Directed testbench for the execute subsystem with reference models and LFSR operands
`timescale 1ns/1ps

module tb_ex_top;

  import ex_alu_pkg::*;
  import ex_mult_pkg::*;

  logic                  clk;
  logic                  rst_n;
  alu_op_e               alu_operator_i;
  logic [DATA_W-1:0]     alu_operand_a_i;
  logic [DATA_W-1:0]     alu_operand_b_i;
  logic [DATA_W-1:0]     alu_operand_c_i;
  logic                  mult_en_i;
  mult_op_e              mult_operator_i;
  logic [DATA_W-1:0]     mult_operand_a_i;
  logic [DATA_W-1:0]     mult_operand_b_i;
  logic [DATA_W-1:0]     mult_operand_c_i;
  logic                  branch_in_ex_i;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i;
  logic                  regfile_alu_we_i;
  logic                  regfile_we_i;
  logic [REG_ADDR_W-1:0] regfile_waddr_i;
  logic                  csr_access_i;
  logic [DATA_W-1:0]     csr_rdata_i;
  logic                  lsu_ready_ex_i;
  logic                  wb_ready_i;
  logic [REG_ADDR_W-1:0] regfile_waddr_wb_o;
  logic                  regfile_we_wb_o;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr_fw_o;
  logic                  regfile_alu_we_fw_o;
  logic [DATA_W-1:0]     regfile_alu_wdata_fw_o;
  logic [DATA_W-1:0]     jump_target_o;
  logic                  branch_decision_o;
  logic                  mult_multicycle_o;
  logic                  ex_ready_o;
  logic                  ex_valid_o;

  // Operand generator state
  logic [15:0]           lfsr_q;
  int                    mismatches;
  int                    timeouts;

  ex_top DUT (.*);

  // 20 ns clock
  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Reference models and helpers
  //////////////////////////////////////////////////////////////////////

  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [DATA_W-1:0] w);
    int i;
    w = '0;
    for (i = 0; i < n; i++)
    begin
      w      = {w[DATA_W-2:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  function automatic logic [DATA_W-1:0] alu_expected(input alu_op_e op,
                                                     input logic [DATA_W-1:0] a,
                                                     input logic [DATA_W-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << sh;
      SRL:     return a >> sh;
      SRA:     return $signed(a) >>> sh;
      SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      SLTU:    return (a < b) ? 32'd1 : 32'd0;
      // Compares leave the result at zero
      default: return '0;
    endcase
  endfunction

  function automatic logic cmp_expected(input alu_op_e op,
                                        input logic [DATA_W-1:0] a,
                                        input logic [DATA_W-1:0] b);
    case (op)
      EQ:      return a == b;
      NE:      return a != b;
      LT:      return $signed(a) < $signed(b);
      GE:      return $signed(a) >= $signed(b);
      LTU:     return a < b;
      GEU:     return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] mult_expected(input mult_op_e op,
                                                      input logic [DATA_W-1:0] a,
                                                      input logic [DATA_W-1:0] b,
                                                      input logic [DATA_W-1:0] c);
    longint          sa;
    longint          sb;
    longint unsigned ua;
    longint unsigned ub;
    logic [63:0]     p;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = {32'h0, a};
    ub = {32'h0, b};
    case (op)
      MUL:     return a * b;
      MAC:     return a * b + c;
      MULH:    p = sa * sb;
      default: p = ua * ub;
    endcase
    return p[63:32];
  endfunction

  task automatic check_word(input string what, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t ns: %s expected %h got %h", $time, what, exp, got);
      mismatches++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t ns: %s expected %b got %b", $time, what, exp, got);
      mismatches++;
    end
  endtask

  // Sample point sits 2 ns after the falling edge
  task automatic wait_valid(input int limit, output int cycles);
    int n;
    n = 0;
    while (ex_valid_o !== 1'b1 && n < limit)
    begin
      @(negedge clk);
      #2;
      n++;
    end
    cycles = n;
    if (ex_valid_o !== 1'b1)
    begin
      $display("ERROR at %0t ns: ex_valid_o did not rise within %0d cycles", $time, limit);
      timeouts++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_alu_ops(input int rounds);
    int                r;
    int                k;
    alu_op_e           op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] c;
    logic [DATA_W-1:0] w;
    for (r = 0; r < rounds; r++)
    begin
      for (k = 0; k < 16; k++)
      begin
        op = alu_op_e'(k[3:0]);
        rand_bits(32, a);
        rand_bits(32, b);
        rand_bits(32, c);
        rand_bits(6, w);
        // Equal operands now and then for EQ and GE
        if (r % 4 == 0)
        begin
          b = a;
        end
        @(negedge clk);
        alu_operator_i      = op;
        alu_operand_a_i     = a;
        alu_operand_b_i     = b;
        alu_operand_c_i     = c;
        regfile_alu_waddr_i = w[4:0];
        regfile_alu_we_i    = w[5];
        #2;
        check_word("alu result", regfile_alu_wdata_fw_o, alu_expected(op, a, b));
        check_bit("branch decision", branch_decision_o, cmp_expected(op, a, b));
        check_word("jump target", jump_target_o, c);
        check_word("fw address", {27'd0, regfile_alu_waddr_fw_o}, {27'd0, w[4:0]});
        check_bit("fw enable", regfile_alu_we_fw_o, w[5]);
      end
    end
  endtask

  task automatic test_branch_stall();
    @(negedge clk);
    branch_in_ex_i = 1'b1;
    wb_ready_i     = 1'b0;
    #2;
    check_bit("ex_ready_o with branch", ex_ready_o, 1'b1);
    check_bit("ex_valid_o with branch", ex_valid_o, 1'b0);
    @(negedge clk);
    branch_in_ex_i = 1'b0;
    wb_ready_i     = 1'b1;
  endtask

  task automatic test_priority();
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] d;
    rand_bits(32, a);
    rand_bits(32, b);
    rand_bits(32, d);
    @(negedge clk);
    alu_operator_i  = ADD;
    alu_operand_a_i = a;
    alu_operand_b_i = b;
    csr_access_i    = 1'b1;
    csr_rdata_i     = d;
    #2;
    check_word("csr over alu", regfile_alu_wdata_fw_o, d);
    @(negedge clk);
    mult_en_i        = 1'b1;
    mult_operator_i  = MUL;
    mult_operand_a_i = a;
    mult_operand_b_i = b;
    #2;
    check_word("mult over csr", regfile_alu_wdata_fw_o, mult_expected(MUL, a, b, d));
    @(negedge clk);
    mult_en_i    = 1'b0;
    csr_access_i = 1'b0;
  endtask

  task automatic test_low_mult(input mult_op_e op);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] c;
    rand_bits(32, a);
    rand_bits(32, b);
    rand_bits(32, c);
    @(negedge clk);
    mult_en_i        = 1'b1;
    mult_operator_i  = op;
    mult_operand_a_i = a;
    mult_operand_b_i = b;
    mult_operand_c_i = c;
    #2;
    check_word("low product", regfile_alu_wdata_fw_o, mult_expected(op, a, b, c));
    check_bit("low product valid", ex_valid_o, 1'b1);
    check_bit("low product multicycle", mult_multicycle_o, 1'b0);
  endtask

  // Optional WB stall while the high result sits in STEP
  task automatic test_high_mult(input mult_op_e op, input int stall_cycles);
    int                n;
    int                waited;
    int                lat_exp;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] exp;
    rand_bits(32, a);
    rand_bits(32, b);
    exp = mult_expected(op, a, b, '0);
    // Second cycle without a stall or right when readiness returns
    lat_exp = (stall_cycles == 0) ? 1 : 0;
    @(negedge clk);
    mult_en_i        = 1'b1;
    mult_operator_i  = op;
    mult_operand_a_i = a;
    mult_operand_b_i = b;
    wb_ready_i       = (stall_cycles == 0);
    #2;
    check_bit("high product first cycle valid", ex_valid_o, 1'b0);
    check_bit("high product first cycle multicycle", mult_multicycle_o, 1'b0);
    for (n = 0; n < stall_cycles; n++)
    begin
      @(negedge clk);
      #2;
      check_bit("stalled valid", ex_valid_o, 1'b0);
      check_bit("stalled multicycle", mult_multicycle_o, 1'b1);
      check_word("stalled high product", regfile_alu_wdata_fw_o, exp);
    end
    if (stall_cycles > 0)
    begin
      @(negedge clk);
      wb_ready_i = 1'b1;
      #2;
    end
    wait_valid(4, waited);
    if (waited != lat_exp)
    begin
      $display("MISMATCH at %0t ns: high product valid after %0d cycles expected %0d",
               $time, waited, lat_exp);
      mismatches++;
    end
    check_word("high product", regfile_alu_wdata_fw_o, exp);
    check_bit("high product multicycle", mult_multicycle_o, 1'b1);
    @(negedge clk);
    mult_en_i = 1'b0;
    #2;
    check_bit("multiplier back in IDLE", mult_multicycle_o, 1'b0);
  endtask

  task automatic test_ex_wb();
    @(negedge clk);
    regfile_we_i    = 1'b1;
    regfile_waddr_i = 5'd7;
    @(negedge clk);
    regfile_we_i    = 1'b0;
    regfile_waddr_i = 5'd12;
    #2;
    check_bit("wb enable after write", regfile_we_wb_o, 1'b1);
    check_word("wb address after write", {27'd0, regfile_waddr_wb_o}, 32'd7);
    @(negedge clk);
    #2;
    // Address stays without a write
    check_bit("wb enable after no write", regfile_we_wb_o, 1'b0);
    check_word("wb address after no write", {27'd0, regfile_waddr_wb_o}, 32'd7);
    @(negedge clk);
    regfile_we_i    = 1'b1;
    regfile_waddr_i = 5'd9;
    @(negedge clk);
    wb_ready_i      = 1'b0;
    regfile_waddr_i = 5'd3;
    repeat (3)
    begin
      #2;
      check_bit("valid under wb stall", ex_valid_o, 1'b0);
      check_bit("wb enable hold", regfile_we_wb_o, 1'b1);
      check_word("wb address hold", {27'd0, regfile_waddr_wb_o}, 32'd9);
      @(negedge clk);
    end
    // LSU stall with WB ready inserts a bubble
    wb_ready_i     = 1'b1;
    lsu_ready_ex_i = 1'b0;
    #2;
    check_bit("valid under lsu stall", ex_valid_o, 1'b0);
    @(negedge clk);
    #2;
    check_bit("wb enable cleared", regfile_we_wb_o, 1'b0);
    check_word("wb address after bubble", {27'd0, regfile_waddr_wb_o}, 32'd9);
    @(negedge clk);
    lsu_ready_ex_i = 1'b1;
    regfile_we_i   = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    clk                 = 1'b0;
    rst_n               = 1'b0;
    alu_operator_i      = ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_en_i           = 1'b0;
    mult_operator_i     = MUL;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    mult_operand_c_i    = '0;
    branch_in_ex_i      = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_alu_we_i    = 1'b0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    wb_ready_i          = 1'b1;
    lfsr_q              = 16'd37346;
    mismatches          = 0;
    timeouts            = 0;

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #2;
    check_bit("wb enable after reset", regfile_we_wb_o, 1'b0);
    check_word("wb address after reset", {27'd0, regfile_waddr_wb_o}, 32'd0);
    check_bit("multicycle after reset", mult_multicycle_o, 1'b0);

    test_alu_ops(8);
    test_branch_stall();
    test_priority();
    test_low_mult(MUL);
    test_low_mult(MAC);
    test_high_mult(MULH, 0);
    test_high_mult(MULHU, 0);
    test_high_mult(MULH, 3);
    test_high_mult(MULHU, 2);
    test_ex_wb();

    $display("Error counts: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
